// ==== common/regmap_pkg.sv ====
`default_nettype none

package regmap_pkg;

    // Opcode map
    localparam logic [7:0] CHIP_ID_ADDR     = 8'hDB;
    localparam logic [7:0] PLL_CSR_ADDR     = 8'h40;
    localparam logic [7:0] DISPLAY_CFG_ADDR = 8'h50;
    localparam logic [7:0] CAMERA_CFG_ADDR  = 8'h60;

    // Fixed device identifier
    localparam logic [7:0] CHIP_ID_VALUE = 8'h81;

    // Display settings, 2 bytes on the wire
    typedef struct packed {
        logic [7:0] brightness;  // Sent first
        logic [7:0] mode;
    } display_cfg_t;

    // Camera settings, 4 bytes on the wire
    typedef struct packed {
        logic [15:0] exposure;  // Sent first, high byte leading
        logic [7:0]  gain;
        logic [7:0]  flags;
    } camera_cfg_t;

    // Mid brightness, default mode
    localparam display_cfg_t DISPLAY_CFG_RESET = 16'h8000;

    // Exposure 0x0100, gain 4, no flags
    localparam camera_cfg_t CAMERA_CFG_RESET = 32'h0100_0400;

endpackage

`default_nettype wire

// ==== common/spi_pkg.sv ====
`default_nettype none

package spi_pkg;

    // Bits per SPI byte, MSB first on the wire
    localparam int BYTE_BITS = 8;

    // Peers on the shared read-back path: system_csr, display, camera
    localparam int N_PEERS = 3;

    // Byte bus broadcast from the peripheral to every peer
    typedef struct packed {
        logic [BYTE_BITS-1:0] opcode;        // Held for the whole transaction
        logic                 opcode_valid;  // One-cycle pulse after the opcode byte
        logic [BYTE_BITS-1:0] operand;       // Last complete operand byte
        logic                 operand_valid; // One-cycle pulse per operand byte
        logic [7:0]           wr_count;      // Index of the operand just written
        logic [7:0]           rd_count;      // Index of the byte now shifting out
    } spi_bus_t;

    // Per-peer answer to the current opcode
    typedef struct packed {
        logic                 hit;   // Opcode belongs to this peer
        logic [BYTE_BITS-1:0] data;  // Read-back byte for rd_count
    } response_t;

endpackage

`default_nettype wire

// ==== logic/config_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module config_register #(
    parameter type        cfg_t       = logic [15:0],
    parameter logic [7:0] ADDRESS     = 8'h00,
    parameter cfg_t       RESET_VALUE = '0
) (
    input  logic               spi_clock,
    input  logic               rst_n,
    input  spi_pkg::spi_bus_t  bus,
    output spi_pkg::response_t response,
    output cfg_t               cfg
);

    localparam int N_BYTES = $bits(cfg_t) / spi_pkg::BYTE_BITS;

    logic [N_BYTES-1:0][spi_pkg::BYTE_BITS-1:0] staging;       // Byte 0 is the MSB
    logic [N_BYTES-1:0][spi_pkg::BYTE_BITS-1:0] staging_next;
    logic [N_BYTES-1:0][spi_pkg::BYTE_BITS-1:0] cfg_bytes;
    logic                                       addressed;
    logic                                       write_en;
    logic                                       last_byte;

    assign addressed = bus.opcode == ADDRESS;
    assign write_en  = addressed && bus.operand_valid && bus.wr_count < N_BYTES;
    assign last_byte = write_en && bus.wr_count == N_BYTES - 1;  // Commit point
    assign cfg_bytes = cfg;

    // Incoming byte merged into its slot
    always_comb begin
        staging_next = staging;
        if (bus.wr_count < N_BYTES) begin
            staging_next[N_BYTES - 1 - int'(bus.wr_count)] = bus.operand;
        end
    end

    // Start each transaction from the live value
    always_ff @(posedge spi_clock) begin
        if (addressed && bus.opcode_valid) staging <= cfg;
        else if (write_en) staging <= staging_next;
    end

    // Short writes never reach cfg
    always_ff @(posedge spi_clock) begin
        if (!rst_n) begin
            cfg <= RESET_VALUE;
        end else if (last_byte) begin
            cfg <= cfg_t'(staging_next);
        end
    end

    always_comb begin
        response.hit = addressed;
        if (bus.rd_count < N_BYTES) begin
            response.data = cfg_bytes[N_BYTES - 1 - int'(bus.rd_count)];
        end else begin
            response.data = '0;  // Past the end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fpga_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpga_ctrl_top (
    input  logic                     spi_clock,
    input  logic                     rst_n,
    input  logic                     select_n,    // Low for a whole transaction
    input  logic                     data_in,
    input  logic                     pll_locked,
    output logic                     data_out,
    output regmap_pkg::display_cfg_t display_cfg,
    output regmap_pkg::camera_cfg_t  camera_cfg,
    output logic                     pllpowerdown_n,
    output logic                     image_buffer_read_en
);

    spi_pkg::spi_bus_t  bus;
    spi_pkg::response_t responses [spi_pkg::N_PEERS];  // Priority order
    logic [7:0]         response_byte;

    spi_peripheral spi_peripheral_i (
        .spi_clock (spi_clock),
        .rst_n     (rst_n),
        .select_n  (select_n),
        .data_in   (data_in),
        .data_out  (data_out),
        .response  (response_byte),
        .bus       (bus)
    );

    // Chip ID and PLL control, highest priority
    system_csr system_csr_i (
        .spi_clock            (spi_clock),
        .rst_n                (rst_n),
        .bus                  (bus),
        .pll_locked           (pll_locked),
        .response             (responses[0]),
        .pllpowerdown_n       (pllpowerdown_n),
        .image_buffer_read_en (image_buffer_read_en)
    );

    config_register #(
        .cfg_t       (regmap_pkg::display_cfg_t),
        .ADDRESS     (regmap_pkg::DISPLAY_CFG_ADDR),
        .RESET_VALUE (regmap_pkg::DISPLAY_CFG_RESET)
    ) display_cfg_i (
        .spi_clock (spi_clock),
        .rst_n     (rst_n),
        .bus       (bus),
        .response  (responses[1]),
        .cfg       (display_cfg)
    );

    config_register #(
        .cfg_t       (regmap_pkg::camera_cfg_t),
        .ADDRESS     (regmap_pkg::CAMERA_CFG_ADDR),
        .RESET_VALUE (regmap_pkg::CAMERA_CFG_RESET)
    ) camera_cfg_i (
        .spi_clock (spi_clock),
        .rst_n     (rst_n),
        .bus       (bus),
        .response  (responses[2]),
        .cfg       (camera_cfg)
    );

    response_arbiter response_arbiter_i (
        .responses (responses),
        .data      (response_byte)
    );

endmodule

`default_nettype wire

// ==== logic/response_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module response_arbiter (
    input  spi_pkg::response_t responses [spi_pkg::N_PEERS],
    output logic [7:0]         data
);

    // Fixed priority, index 0 strongest
    // Walk from the weakest so the lowest hitting index is written last
    always_comb begin
        data = '0;  // Unmapped opcode reads zero
        for (int i = spi_pkg::N_PEERS - 1; i >= 0; i--) begin
            if (responses[i].hit) begin
                data = responses[i].data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/system_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module system_csr (
    input  logic               spi_clock,
    input  logic               rst_n,
    input  spi_pkg::spi_bus_t  bus,
    input  logic               pll_locked,
    output spi_pkg::response_t response,
    output logic               pllpowerdown_n,
    output logic               image_buffer_read_en
);

    logic pll_csr_write;

    // Only the first operand byte is a CSR write
    assign pll_csr_write = bus.operand_valid
                        && bus.opcode == regmap_pkg::PLL_CSR_ADDR
                        && bus.wr_count == 8'd0;

    always_ff @(posedge spi_clock) begin
        if (!rst_n) begin
            pllpowerdown_n       <= 1'b1;  // PLL running out of reset
            image_buffer_read_en <= 1'b0;
        end else if (pll_csr_write) begin
            pllpowerdown_n <= bus.operand[0];
            // SPI clock may feed the image buffer only with the PLL off
            image_buffer_read_en <= bus.operand[1] & ~bus.operand[0];
        end
    end

    // Same byte for every read position
    always_comb begin
        response = '0;
        case (bus.opcode)
            regmap_pkg::CHIP_ID_ADDR: begin
                response.hit  = 1'b1;
                response.data = regmap_pkg::CHIP_ID_VALUE;
            end
            regmap_pkg::PLL_CSR_ADDR: begin
                response.hit  = 1'b1;
                // Lock status for the host before it flips the buffer clock
                response.data = {5'b0, pll_locked, image_buffer_read_en, pllpowerdown_n};
            end
            default: begin
                response = '0;  // Not ours
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== project.f ====
common/spi_pkg.sv
common/regmap_pkg.sv
spi/spi_peripheral.sv
logic/response_arbiter.sv
logic/system_csr.sv
logic/config_register.sv
logic/fpga_ctrl_top.sv
test/fpga_ctrl_assert.sv
test/tb_fpga_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_fpga_ctrl -f project.f

output=$(./obj_dir/Vtb_fpga_ctrl || true)
echo "$output"
echo "$output" | grep -qx "TB PASSED"

// ==== spi/spi_peripheral.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_peripheral (
    input  logic             spi_clock,
    input  logic             rst_n,
    input  logic             select_n,
    input  logic             data_in,
    output logic             data_out,
    input  logic [7:0]       response,
    output spi_pkg::spi_bus_t bus
);

    logic [$clog2(spi_pkg::BYTE_BITS)-1:0] bit_count;   // Position within current byte
    logic [spi_pkg::BYTE_BITS-2:0]         shift_in;    // First 7 bits of the byte
    logic [spi_pkg::BYTE_BITS-2:0]         shift_out;   // Remaining response bits
    logic [spi_pkg::BYTE_BITS-1:0]         rx_byte;
    logic [spi_pkg::BYTE_BITS-1:0]         opcode;
    logic [spi_pkg::BYTE_BITS-1:0]         operand;
    logic                                  opcode_done; // Opcode byte already taken
    logic                                  opcode_valid;
    logic                                  operand_valid;
    logic [7:0]                            wr_count;
    logic [7:0]                            rd_count;
    logic                                  byte_end;

    assign rx_byte  = {shift_in, data_in};  // Completed byte at the 8th edge
    assign byte_end = &bit_count;

    // Control state, cleared by reset or a deselected host
    always_ff @(posedge spi_clock) begin
        if (!rst_n || select_n) begin
            bit_count     <= '0;  // Partial byte dropped
            opcode_done   <= 1'b0;
            opcode_valid  <= 1'b0;
            operand_valid <= 1'b0;
            wr_count      <= '0;
            rd_count      <= '0;
        end else begin
            bit_count     <= bit_count + 1'b1;
            opcode_valid  <= byte_end && !opcode_done;
            operand_valid <= byte_end && opcode_done;
            if (byte_end) begin
                if (!opcode_done) begin
                    opcode_done <= 1'b1;
                end else begin
                    // Written byte has the index that was being read
                    wr_count <= rd_count;
                    rd_count <= rd_count + 1'b1;
                end
            end
        end
    end

    // Shift registers and captured bytes
    always_ff @(posedge spi_clock) begin
        if (!select_n) begin
            shift_in <= {shift_in[spi_pkg::BYTE_BITS-3:0], data_in};
            if (bit_count == '0) begin
                shift_out <= response[spi_pkg::BYTE_BITS-2:0];  // Bit 7 already on the pin
            end else begin
                shift_out <= shift_out << 1;
            end
            if (byte_end && !opcode_done) opcode <= rx_byte;
            if (byte_end && opcode_done) operand <= rx_byte;
        end
    end

    // Bit 7 straight from the arbiter, the rest from shift_out
    always_comb begin
        if (!opcode_done) data_out = 1'b0;               // Nothing to return yet
        else if (bit_count == '0) data_out = response[7];
        else data_out = shift_out[spi_pkg::BYTE_BITS-2];
    end

    assign bus = '{
        opcode:        opcode,
        opcode_valid:  opcode_valid,
        operand:       operand,
        operand_valid: operand_valid,
        wr_count:      wr_count,
        rd_count:      rd_count
    };

endmodule

`default_nettype wire

// ==== test/fpga_ctrl_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpga_ctrl_assert (
    input logic spi_clock,
    input logic rst_n,
    input logic select_n,
    input logic operand_valid,
    input logic pllpowerdown_n,
    input logic image_buffer_read_en
);

    // SPI clock on the image buffer only with the PLL down
    ibuf_needs_pll_off: assert property (
        @(posedge spi_clock) disable iff (!rst_n)
        image_buffer_read_en |-> !pllpowerdown_n
    ) else $error("image_buffer_read_en high while pllpowerdown_n is high");

    // operand_valid is registered, so it clears one edge after deselect
    no_operand_when_idle: assert property (
        @(posedge spi_clock) disable iff (!rst_n)
        select_n |=> !operand_valid
    ) else $error("operand_valid pulsed with select_n high");

    reset_levels: assert property (
        @(posedge spi_clock)
        !rst_n |=> (pllpowerdown_n && !image_buffer_read_en)
    ) else $error("PLL control outputs left their reset levels during reset");

endmodule

bind fpga_ctrl_top fpga_ctrl_assert fpga_ctrl_assert_i (
    .spi_clock            (spi_clock),
    .rst_n                (rst_n),
    .select_n             (select_n),
    .operand_valid        (bus.operand_valid),
    .pllpowerdown_n       (pllpowerdown_n),
    .image_buffer_read_en (image_buffer_read_en)
);

`default_nettype wire

// ==== test/tb_fpga_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_ctrl;

    localparam int N_ROWS   = 17;
    localparam int N_RANDOM = 6;   // Camera plus display write per pass
    localparam int LIMIT_NS = (N_ROWS + 2 * N_RANDOM) * 6 * 8 * 20 + 2000;

    // One host transaction and what it must produce
    typedef struct packed {
        logic [7:0]      opcode;
        logic [2:0]      n_ops;    // Operand bytes after the opcode
        logic [3:0]      cut_bits; // Bits sent of the final byte, 8 means whole
        logic            locked;   // pll_locked during the row
        logic [0:3][7:0] wr;       // Byte 0 goes first
        logic [0:3][7:0] rd;       // Expected read-back per operand byte
        logic [15:0]     disp;
        logic [31:0]     cam;
        logic [1:0]      ctrl;     // {pllpowerdown_n, image_buffer_read_en}
    } row_t;

    logic                     spi_clock;
    logic                     rst_n;
    logic                     select_n;
    logic                     data_in;
    logic                     pll_locked;
    logic                     data_out;
    regmap_pkg::display_cfg_t display_cfg;
    regmap_pkg::camera_cfg_t  camera_cfg;
    logic                     pllpowerdown_n;
    logic                     image_buffer_read_en;
    logic [31:0]              lcg_state;

    row_t rows [N_ROWS] = '{
        '{8'h40, 3'd1, 4'd8, 1'b1, 32'h01000000, 32'h05000000, 16'h8000, 32'h01000400, 2'b10},
        '{8'hDB, 3'd3, 4'd8, 1'b1, 32'h00000000, 32'h81818100, 16'h8000, 32'h01000400, 2'b10},
        '{8'h7E, 3'd2, 4'd8, 1'b1, 32'h12340000, 32'h00000000, 16'h8000, 32'h01000400, 2'b10},
        '{8'h50, 3'd2, 4'd8, 1'b1, 32'h5A3C0000, 32'h80000000, 16'h5A3C, 32'h01000400, 2'b10},
        '{8'h50, 3'd2, 4'd8, 1'b1, 32'h12340000, 32'h5A3C0000, 16'h1234, 32'h01000400, 2'b10},
        '{8'h50, 3'd1, 4'd8, 1'b1, 32'hFF000000, 32'h12000000, 16'h1234, 32'h01000400, 2'b10},
        '{8'h50, 3'd3, 4'd8, 1'b1, 32'hABCDEE00, 32'h12340000, 16'hABCD, 32'h01000400, 2'b10},
        '{8'h60, 3'd4, 4'd8, 1'b1, 32'hDEADBEEF, 32'h01000400, 16'hABCD, 32'hDEADBEEF, 2'b10},
        '{8'h60, 3'd3, 4'd8, 1'b1, 32'h11223300, 32'hDEADBE00, 16'hABCD, 32'hDEADBEEF, 2'b10},
        '{8'h60, 3'd4, 4'd8, 1'b1, 32'h002A1081, 32'hDEADBEEF, 16'hABCD, 32'h002A1081, 2'b10},
        '{8'h40, 3'd1, 4'd8, 1'b0, 32'h03000000, 32'h01000000, 16'hABCD, 32'h002A1081, 2'b10},
        '{8'h40, 3'd1, 4'd8, 1'b1, 32'h02000000, 32'h05000000, 16'hABCD, 32'h002A1081, 2'b01},
        '{8'h40, 3'd2, 4'd8, 1'b0, 32'h02000000, 32'h02020000, 16'hABCD, 32'h002A1081, 2'b01},
        '{8'h40, 3'd1, 4'd8, 1'b1, 32'h03000000, 32'h06000000, 16'hABCD, 32'h002A1081, 2'b10},
        '{8'h50, 3'd2, 4'd5, 1'b1, 32'h77660000, 32'hAB000000, 16'hABCD, 32'h002A1081, 2'b10},
        '{8'h60, 3'd0, 4'd4, 1'b1, 32'h00000000, 32'h00000000, 16'hABCD, 32'h002A1081, 2'b10},
        '{8'h50, 3'd2, 4'd8, 1'b1, 32'h9C3E0000, 32'hABCD0000, 16'h9C3E, 32'h002A1081, 2'b10}
    };

    fpga_ctrl_top fpga_ctrl_top_i (
        .spi_clock            (spi_clock),
        .rst_n                (rst_n),
        .select_n             (select_n),
        .data_in              (data_in),
        .pll_locked           (pll_locked),
        .data_out             (data_out),
        .display_cfg          (display_cfg),
        .camera_cfg           (camera_cfg),
        .pllpowerdown_n       (pllpowerdown_n),
        .image_buffer_read_en (image_buffer_read_en)
    );

    initial begin
        spi_clock = 1'b0;
        forever #10 spi_clock = ~spi_clock;  // 20 ns period
    end

    initial begin
        #(LIMIT_NS);
        $display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
        $display("TB FAILED");
        $fatal(1, "Watchdog expired");
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "Value check failed");
        end
    endtask

    // Sample data_out, then drive the next bit; DUT takes it on the rising edge
    task automatic shift_bit(input logic bit_out, output logic bit_in);
        @(negedge spi_clock);
        bit_in   = data_out;  // Stable since the last rising edge
        select_n = 1'b0;
        data_in  = bit_out;
    endtask

    task automatic spi_transfer(input logic [7:0] opcode, input int n_ops, input int cut_bits,
                                input logic [0:3][7:0] wr, output logic [0:3][7:0] rd);
        logic b;
        int   n_bits;
        rd     = '0;
        n_bits = (n_ops == 0) ? cut_bits : 8;  // Opcode itself may be cut short
        for (int i = 7; i >= 8 - n_bits; i--) begin
            shift_bit(opcode[i], b);
            check_value("data_out during opcode", 32'(0), 32'(b));
        end
        for (int k = 0; k < n_ops; k++) begin
            n_bits = (k == n_ops - 1) ? cut_bits : 8;
            for (int i = 7; i >= 8 - n_bits; i--) begin
                shift_bit(wr[k][i], b);
                rd[k][i] = b;
            end
        end
        @(negedge spi_clock);
        select_n = 1'b1;
        repeat (2) @(negedge spi_clock);  // operand_valid edge, then register edge
    endtask

    // Only whole bytes have a defined read-back
    task automatic transfer_and_check(input logic [7:0] opcode, input int n_ops,
                                      input int cut_bits, input logic [0:3][7:0] wr,
                                      input logic [0:3][7:0] exp_rd, input string what);
        logic [0:3][7:0] rd;
        spi_transfer(opcode, n_ops, cut_bits, wr, rd);
        for (int k = 0; k < n_ops; k++) begin
            if (k < n_ops - 1 || cut_bits == 8) begin
                check_value($sformatf("data_out %s byte %0d", what, k),
                            32'(exp_rd[k]), 32'(rd[k]));
            end
        end
    endtask

    task automatic check_outputs(input logic [15:0] disp, input logic [31:0] cam,
                                 input logic [1:0] ctrl);
        check_value("display_cfg", 32'(disp), 32'(display_cfg));
        check_value("camera_cfg", cam, 32'(camera_cfg));
        check_value("pllpowerdown_n", 32'(ctrl[1]), 32'(pllpowerdown_n));
        check_value("image_buffer_read_en", 32'(ctrl[0]), 32'(image_buffer_read_en));
    endtask

    initial begin
        logic [15:0] disp_model;
        logic [31:0] cam_model;
        logic [1:0]  ctrl_model;
        rst_n      = 1'b0;
        select_n   = 1'b1;
        data_in    = 1'b0;
        pll_locked = 1'b0;
        lcg_state  = 32'd97;
        repeat (2) @(negedge spi_clock);  // Two rising edges in reset
        rst_n = 1'b1;

        for (int r = 0; r < N_ROWS; r++) begin
            pll_locked = rows[r].locked;
            transfer_and_check(rows[r].opcode, int'(rows[r].n_ops), int'(rows[r].cut_bits),
                               rows[r].wr, rows[r].rd, $sformatf("row %0d", r));
            check_outputs(rows[r].disp, rows[r].cam, rows[r].ctrl);
        end

        // Random full writes, previous value reads back MSB first
        disp_model = rows[N_ROWS-1].disp;
        cam_model  = rows[N_ROWS-1].cam;
        ctrl_model = rows[N_ROWS-1].ctrl;
        for (int n = 0; n < N_RANDOM; n++) begin
            lcg_state = lcg_step(lcg_state);
            transfer_and_check(regmap_pkg::CAMERA_CFG_ADDR, 4, 8, lcg_state, cam_model,
                               "random camera");
            cam_model = lcg_state;
            check_outputs(disp_model, cam_model, ctrl_model);
            lcg_state = lcg_step(lcg_state);
            transfer_and_check(regmap_pkg::DISPLAY_CFG_ADDR, 2, 8, {lcg_state[31:16], 16'h0},
                               {disp_model, 16'h0}, "random display");
            disp_model = lcg_state[31:16];  // Upper LCG bits
            check_outputs(disp_model, cam_model, ctrl_model);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
